// ==== rtl/wb_axi4l_pkg.sv ====
package wb_axi4l_pkg;

    // ------------------------------------------------------------------------
    // Bus widths shared by the Wishbone and AXI4-Lite sides
    // ------------------------------------------------------------------------
    localparam int DAT_W      = 64;
    localparam int SEL_W      = DAT_W / 8;
    localparam int AXI_ADDR_W = 40;

    typedef enum logic [1:0] {
        AXI_OKAY   = 2'b00,
        AXI_SLVERR = 2'b10,
        AXI_DECERR = 2'b11   // No register at this address
    } axi_resp_e;

    // ------------------------------------------------------------------------
    // Channel payloads
    // ------------------------------------------------------------------------

    // Shared by AW and AR
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
    } axi4l_addr_t;

    typedef struct packed {
        logic [DAT_W-1:0] data;
        logic [SEL_W-1:0] strb;   // One bit per byte lane
    } axi4l_wdat_t;

    typedef struct packed {
        logic [DAT_W-1:0] data;
        axi_resp_e        resp;
    } axi4l_rdat_t;

endpackage

// ==== rtl/axi4l_chan_slice.sv ====
`timescale 1ns/100ps

module axi4l_chan_slice
    import wb_axi4l_pkg::*;
#(
    parameter type T = axi4l_addr_t
) (
    input  logic clk_i,
    input  logic rst_n_i,

    input  logic s_valid_i,
    output logic s_ready_o,
    input  T     s_data_i,

    output logic m_valid_o,
    input  logic m_ready_i,
    output T     m_data_o
);

    logic valid_q;
    T     data_q;

    // Free when empty, or when the held item leaves in this cycle
    assign s_ready_o = !valid_q || m_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (s_ready_o) begin
            valid_q <= s_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_valid_i && s_ready_o) begin
            data_q <= s_data_i;
        end
    end

    assign m_valid_o = valid_q;
    assign m_data_o  = data_q;

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // A stalled output must keep its item until the consumer takes it
    a_hold_stalled: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o)
    );

endmodule

// ==== rtl/wb_to_axi4l_bridge.sv ====
`timescale 1ns/100ps

module wb_to_axi4l_bridge
    import wb_axi4l_pkg::*;
#(
    parameter int WB_ADR_WIDTH = 37
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic [WB_ADR_WIDTH-1:0] wb_adr_i,
    input  logic [DAT_W-1:0]        wb_dat_i,
    input  logic [SEL_W-1:0]        wb_sel_i,
    input  logic                    wb_we_i,
    input  logic                    wb_stb_i,
    output logic [DAT_W-1:0]        wb_dat_o,
    output logic                    wb_ack_o,

    output logic                    m_aw_valid_o,
    input  logic                    m_aw_ready_i,
    output axi4l_addr_t             m_aw_o,
    output logic                    m_w_valid_o,
    input  logic                    m_w_ready_i,
    output axi4l_wdat_t             m_w_o,
    input  logic                    m_b_valid_i,
    output logic                    m_b_ready_o,
    input  axi_resp_e               m_b_resp_i,
    output logic                    m_ar_valid_o,
    input  logic                    m_ar_ready_i,
    output axi4l_addr_t             m_ar_o,
    input  logic                    m_r_valid_i,
    output logic                    m_r_ready_o,
    input  axi4l_rdat_t             m_r_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_ACK
    } state_e;

    state_e           state;
    logic             aw_sent;
    logic             w_sent;
    logic             ack_q;
    logic [DAT_W-1:0] dat_q;

    axi4l_addr_t      req_addr;
    axi4l_wdat_t      req_wdat;
    logic             aw_in_valid, aw_in_ready;
    logic             w_in_valid, w_in_ready;
    logic             ar_in_valid, ar_in_ready;
    logic             aw_fire, w_fire, ar_fire;
    logic             b_fire, r_fire;
    logic             issue_done;

    // The master holds its inputs until ack, so they feed the slices directly
    assign req_addr.addr = AXI_ADDR_W'({wb_adr_i, 3'b000});   // Word to byte address
    assign req_wdat.data = wb_dat_i;
    assign req_wdat.strb = wb_sel_i;

    assign aw_in_valid = (state == ST_ISSUE) && wb_we_i && !aw_sent;
    assign w_in_valid  = (state == ST_ISSUE) && wb_we_i && !w_sent;
    assign ar_in_valid = (state == ST_ISSUE) && !wb_we_i;

    assign aw_fire = aw_in_valid && aw_in_ready;
    assign w_fire  = w_in_valid && w_in_ready;
    assign ar_fire = ar_in_valid && ar_in_ready;

    // AW and W may be taken in different cycles
    assign issue_done = wb_we_i ? ((aw_sent || aw_fire) && (w_sent || w_fire)) : ar_fire;

    assign m_b_ready_o = (state == ST_WAIT) && wb_we_i;
    assign m_r_ready_o = (state == ST_WAIT) && !wb_we_i;
    assign b_fire      = m_b_valid_i && m_b_ready_o;
    assign r_fire      = m_r_valid_i && m_r_ready_o;

    // ------------------------------------------------------------------------
    // Access FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= ST_IDLE;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wb_stb_i) state <= ST_ISSUE;
                end
                ST_ISSUE: begin
                    if (aw_fire) aw_sent <= 1'b1;
                    if (w_fire) w_sent <= 1'b1;
                    if (issue_done) begin
                        state   <= ST_WAIT;
                        aw_sent <= 1'b0;
                        w_sent  <= 1'b0;
                    end
                end
                ST_WAIT: begin
                    if (b_fire || r_fire) begin
                        state <= ST_ACK;
                        ack_q <= 1'b1;
                    end
                end
                ST_ACK: begin
                    // Stay here until stb falls so the same access is not issued twice
                    if (!wb_stb_i) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Write acks return the B response in the low bits
    always_ff @(posedge clk_i) begin
        if (r_fire) begin
            dat_q <= (m_r_i.resp == AXI_OKAY) ? m_r_i.data : '0;
        end else if (b_fire) begin
            dat_q <= DAT_W'(m_b_resp_i);
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;

    // ------------------------------------------------------------------------
    // Request channel slices
    // ------------------------------------------------------------------------
    axi4l_chan_slice #(.T(axi4l_addr_t)) u_aw_slice (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .s_valid_i (aw_in_valid),
        .s_ready_o (aw_in_ready),
        .s_data_i  (req_addr),
        .m_valid_o (m_aw_valid_o),
        .m_ready_i (m_aw_ready_i),
        .m_data_o  (m_aw_o)
    );

    axi4l_chan_slice #(.T(axi4l_wdat_t)) u_w_slice (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .s_valid_i (w_in_valid),
        .s_ready_o (w_in_ready),
        .s_data_i  (req_wdat),
        .m_valid_o (m_w_valid_o),
        .m_ready_i (m_w_ready_i),
        .m_data_o  (m_w_o)
    );

    axi4l_chan_slice #(.T(axi4l_addr_t)) u_ar_slice (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .s_valid_i (ar_in_valid),
        .s_ready_o (ar_in_ready),
        .s_data_i  (req_addr),
        .m_valid_o (m_ar_valid_o),
        .m_ready_i (m_ar_ready_i),
        .m_data_o  (m_ar_o)
    );

    a_ack_single: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o
    );

endmodule

// ==== rtl/axi4l_reg_bank.sv ====
`timescale 1ns/100ps

module axi4l_reg_bank
    import wb_axi4l_pkg::*;
#(
    parameter int REG_COUNT = 16
) (
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        s_aw_valid_i,
    output logic        s_aw_ready_o,
    input  axi4l_addr_t s_aw_i,
    input  logic        s_w_valid_i,
    output logic        s_w_ready_o,
    input  axi4l_wdat_t s_w_i,
    output logic        s_b_valid_o,
    input  logic        s_b_ready_i,
    output axi_resp_e   s_b_resp_o,
    input  logic        s_ar_valid_i,
    output logic        s_ar_ready_o,
    input  axi4l_addr_t s_ar_i,
    output logic        s_r_valid_o,
    input  logic        s_r_ready_i,
    output axi4l_rdat_t s_r_o
);

    localparam int IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

    logic [DAT_W-1:0]        regs [REG_COUNT];

    logic                    aw_full, w_full;
    axi4l_addr_t             aw_q;
    axi4l_wdat_t             w_q;
    logic                    b_valid_q;
    axi_resp_e               b_resp_q;

    logic [AXI_ADDR_W-4:0]   wr_word, rd_word;
    logic [IDX_W-1:0]        wr_idx, rd_idx;
    logic                    wr_hit, rd_hit;
    logic                    wr_go;
    logic                    r_in_valid, r_in_ready;
    axi4l_rdat_t             r_in;

    // ------------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------------
    assign s_aw_ready_o = !aw_full && !b_valid_q;
    assign s_w_ready_o  = !w_full && !b_valid_q;

    assign wr_word = aw_q.addr[AXI_ADDR_W-1:3];   // Byte offset within the word is ignored
    assign wr_hit  = wr_word < REG_COUNT;
    assign wr_idx  = wr_word[IDX_W-1:0];
    assign wr_go   = aw_full && w_full && !b_valid_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            aw_full   <= 1'b0;
            w_full    <= 1'b0;
            b_valid_q <= 1'b0;
            b_resp_q  <= AXI_OKAY;
        end else begin
            if (s_aw_valid_i && s_aw_ready_o) aw_full <= 1'b1;
            if (s_w_valid_i && s_w_ready_o) w_full <= 1'b1;
            if (wr_go) begin
                aw_full   <= 1'b0;
                w_full    <= 1'b0;
                b_valid_q <= 1'b1;
                b_resp_q  <= wr_hit ? AXI_OKAY : AXI_DECERR;
            end else if (s_b_ready_i) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_aw_valid_i && s_aw_ready_o) aw_q <= s_aw_i;
        if (s_w_valid_i && s_w_ready_o) w_q <= s_w_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_go && wr_hit) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (w_q.strb[b]) regs[wr_idx][8*b +: 8] <= w_q.data[8*b +: 8];
            end
        end
    end

    assign s_b_valid_o = b_valid_q;
    assign s_b_resp_o  = b_resp_q;

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------
    assign rd_word = s_ar_i.addr[AXI_ADDR_W-1:3];
    assign rd_hit  = rd_word < REG_COUNT;
    assign rd_idx  = rd_word[IDX_W-1:0];

    // One read in flight at a time
    assign s_ar_ready_o = r_in_ready && !s_r_valid_o;
    assign r_in_valid   = s_ar_valid_i && s_ar_ready_o;
    assign r_in.data    = rd_hit ? regs[rd_idx] : '0;
    assign r_in.resp    = rd_hit ? AXI_OKAY : AXI_DECERR;

    axi4l_chan_slice #(.T(axi4l_rdat_t)) u_r_slice (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .s_valid_i (r_in_valid),
        .s_ready_o (r_in_ready),
        .s_data_i  (r_in),
        .m_valid_o (s_r_valid_o),
        .m_ready_i (s_r_ready_i),
        .m_data_o  (s_r_o)
    );

    a_b_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        s_b_valid_o && !s_b_ready_i |=> s_b_valid_o && $stable(s_b_resp_o)
    );

endmodule

// ==== rtl/wb_axi4l_top.sv ====
`timescale 1ns/100ps

module wb_axi4l_top
    import wb_axi4l_pkg::*;
#(
    parameter int WB_ADR_WIDTH = 37,
    parameter int REG_COUNT    = 16
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic [WB_ADR_WIDTH-1:0] wb_adr_i,
    input  logic [DAT_W-1:0]        wb_dat_i,
    input  logic [SEL_W-1:0]        wb_sel_i,
    input  logic                    wb_we_i,
    input  logic                    wb_stb_i,
    output logic [DAT_W-1:0]        wb_dat_o,
    output logic                    wb_ack_o
);

    // ------------------------------------------------------------------------
    // AXI4-Lite link between the bridge and the register bank
    // ------------------------------------------------------------------------
    logic        aw_valid, aw_ready;
    axi4l_addr_t aw;
    logic        w_valid, w_ready;
    axi4l_wdat_t w;
    logic        b_valid, b_ready;
    axi_resp_e   b_resp;
    logic        ar_valid, ar_ready;
    axi4l_addr_t ar;
    logic        r_valid, r_ready;
    axi4l_rdat_t r;

    wb_to_axi4l_bridge #(
        .WB_ADR_WIDTH (WB_ADR_WIDTH)
    ) u_bridge (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_we_i      (wb_we_i),
        .wb_stb_i     (wb_stb_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .m_aw_valid_o (aw_valid),
        .m_aw_ready_i (aw_ready),
        .m_aw_o       (aw),
        .m_w_valid_o  (w_valid),
        .m_w_ready_i  (w_ready),
        .m_w_o        (w),
        .m_b_valid_i  (b_valid),
        .m_b_ready_o  (b_ready),
        .m_b_resp_i   (b_resp),
        .m_ar_valid_o (ar_valid),
        .m_ar_ready_i (ar_ready),
        .m_ar_o       (ar),
        .m_r_valid_i  (r_valid),
        .m_r_ready_o  (r_ready),
        .m_r_i        (r)
    );

    axi4l_reg_bank #(
        .REG_COUNT (REG_COUNT)
    ) u_reg_bank (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .s_aw_valid_i (aw_valid),
        .s_aw_ready_o (aw_ready),
        .s_aw_i       (aw),
        .s_w_valid_i  (w_valid),
        .s_w_ready_o  (w_ready),
        .s_w_i        (w),
        .s_b_valid_o  (b_valid),
        .s_b_ready_i  (b_ready),
        .s_b_resp_o   (b_resp),
        .s_ar_valid_i (ar_valid),
        .s_ar_ready_o (ar_ready),
        .s_ar_i       (ar),
        .s_r_valid_o  (r_valid),
        .s_r_ready_i  (r_ready),
        .s_r_o        (r)
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        // Released on a falling edge, after RST_CYCLES rising edges
        #(PERIOD * RST_CYCLES);
        rst_n_o = 1'b1;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== tests/tb_wb_axi4l_top.sv ====
`timescale 1ns/100ps

module tb_wb_axi4l_top
    import wb_axi4l_pkg::*;
#(
    parameter int WB_ADR_WIDTH = 37,
    parameter int REG_COUNT    = 16
) ();

    localparam int          CLK_PERIOD     = 40;
    localparam int          N_RANDOM       = 200;
    localparam int          N_ACCESS       = 4 * REG_COUNT + 12 + N_RANDOM;
    localparam int          TIMEOUT_CYCLES = N_ACCESS * 20 + 100;
    localparam logic [31:0] PART_SEL       = 32'hf0_81_5a_01;   // Four select patterns

    // AXI response codes, seen in the low bits of wb_dat_o on a write ack
    localparam logic [DAT_W-1:0] RESP_OKAY   = 'h0;
    localparam logic [DAT_W-1:0] RESP_DECERR = 'h3;

    logic                    clk, rst_n;
    logic [WB_ADR_WIDTH-1:0] wb_adr;
    logic [DAT_W-1:0]        wb_dat_w, wb_dat_r;
    logic [SEL_W-1:0]        wb_sel;
    logic                    wb_we, wb_stb, wb_ack;

    logic [DAT_W-1:0]        shadow [REG_COUNT];
    bit                      exp_is_read [$];
    logic [DAT_W-1:0]        exp_data [$];
    int                      errors, checks, accesses, acks;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    wb_axi4l_top #(
        .WB_ADR_WIDTH (WB_ADR_WIDTH),
        .REG_COUNT    (REG_COUNT)
    ) UUT (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_we_i  (wb_we),
        .wb_stb_i (wb_stb),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // Applies one access to the shadow bank and returns what wb_dat_o shows at its ack
    function automatic logic [DAT_W-1:0] model_access(input logic we,
                                                      input logic [WB_ADR_WIDTH-1:0] adr,
                                                      input logic [DAT_W-1:0] dat,
                                                      input logic [SEL_W-1:0] sel);
        logic [DAT_W-1:0] result;
        result = we ? RESP_DECERR : '0;   // Reads outside the bank return zero
        if (adr < REG_COUNT) begin
            if (we) begin
                result = RESP_OKAY;
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel[b]) shadow[adr][8*b +: 8] = dat[8*b +: 8];
                end
            end else begin
                result = shadow[adr];
            end
        end
        return result;
    endfunction

    // One classic Wishbone access, inputs held until ack
    task automatic bus_access(input logic we, input logic [WB_ADR_WIDTH-1:0] adr,
                              input logic [DAT_W-1:0] dat, input logic [SEL_W-1:0] sel);
        exp_data.push_back(model_access(we, adr, dat, sel));
        exp_is_read.push_back(!we);
        accesses++;
        @(negedge clk);
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        wb_we    = we;
        wb_stb   = 1'b1;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        wb_stb = 1'b0;
        @(negedge clk);
        assert (!wb_ack) else begin
            $display("Access to word address %0h at %0t ns received a second ack", adr, $time);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) $display("test %s: passed", name);
        else $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    // ------------------------------------------------------------------------
    // Response checker
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : check_ack
        bit               is_read;
        logic [DAT_W-1:0] expected;
        if (rst_n && wb_ack) begin
            acks++;
            if (exp_is_read.size() == 0) begin
                $display("ack at %0t ns arrived with no access outstanding", $time);
                errors++;
            end else begin
                is_read  = exp_is_read.pop_front();
                expected = exp_data.pop_front();
                checks++;
                assert (wb_dat_r === expected) else begin
                    $display("[FAIL] %0t ns: wb_dat_o expected %h, got %h on a %s ack",
                             $time, expected, wb_dat_r, is_read ? "read" : "write");
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, wb_ack_o never came for the access in progress",
                 TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int                      mark;
        logic                    we;
        logic [WB_ADR_WIDTH-1:0] adr;
        logic [WB_ADR_WIDTH-1:0] far_adr;
        logic [DAT_W-1:0]        dat;
        logic [SEL_W-1:0]        sel;

        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        wb_we    = 1'b0;
        wb_stb   = 1'b0;
        errors   = 0;
        checks   = 0;
        accesses = 0;
        acks     = 0;
        far_adr  = WB_ADR_WIDTH'(1) << (WB_ADR_WIDTH - 1);
        for (int i = 0; i < REG_COUNT; i++) shadow[i] = '0;
        void'($urandom(32'h6485dfe4));

        @(posedge rst_n);
        mark = errors;
        repeat (10) begin
            @(negedge clk);
            assert (!wb_ack) else begin
                $display("[FAIL] %0t ns: wb_ack_o expected 0, got 1", $time);
                errors++;
            end
        end
        for (int i = 0; i < REG_COUNT; i++) bus_access(1'b0, WB_ADR_WIDTH'(i), '0, '0);
        report_test("reset state", mark);

        mark = errors;
        for (int i = 0; i < REG_COUNT; i++) begin
            bus_access(1'b1, WB_ADR_WIDTH'(i), {$urandom(), $urandom()}, '1);
        end
        for (int i = 0; i < REG_COUNT; i++) bus_access(1'b0, WB_ADR_WIDTH'(i), '0, '0);
        report_test("full word write and read", mark);

        mark = errors;
        for (int k = 0; k < 4; k++) begin
            adr = WB_ADR_WIDTH'((5 * k + 2) % REG_COUNT);
            bus_access(1'b1, adr, {$urandom(), $urandom()}, PART_SEL[8*k +: 8]);
            bus_access(1'b0, adr, '0, '0);
        end
        report_test("partial byte selects", mark);

        // All ones would show up in register 0 if the decode dropped high bits
        mark = errors;
        bus_access(1'b1, WB_ADR_WIDTH'(REG_COUNT), '1, '1);
        bus_access(1'b1, far_adr, '1, '1);
        bus_access(1'b0, WB_ADR_WIDTH'(REG_COUNT), '0, '0);
        bus_access(1'b0, far_adr, '0, '0);
        for (int i = 0; i < REG_COUNT; i++) bus_access(1'b0, WB_ADR_WIDTH'(i), '0, '0);
        report_test("out of range accesses", mark);

        mark = errors;
        for (int n = 0; n < N_RANDOM; n++) begin
            we = 1'($urandom_range(0, 1));
            if ($urandom_range(0, 7) == 0) adr = WB_ADR_WIDTH'({$urandom(), $urandom()});
            else adr = WB_ADR_WIDTH'($urandom_range(0, REG_COUNT + 3));
            dat = {$urandom(), $urandom()};
            sel = SEL_W'($urandom());
            bus_access(we, adr, dat, sel);
        end
        report_test("random accesses", mark);

        @(negedge clk);
        assert (acks == accesses && exp_is_read.size() == 0) else begin
            $display("Saw %0d acks for %0d accesses", acks, accesses);
            errors++;
        end
        $display("accesses: %0d, acks: %0d, data checks: %0d, errors: %0d",
                 accesses, acks, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/wb_axi4l_pkg.sv
rtl/axi4l_chan_slice.sv
rtl/wb_to_axi4l_bridge.sv
rtl/axi4l_reg_bank.sv
rtl/wb_axi4l_top.sv
tests/tb_clk_gen.sv
tests/tb_wb_axi4l_top.sv

// ==== Makefile ====
# Verilator build and run for the Wishbone to AXI4-Lite bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_axi4l_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: run build clean

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
